// File: verilog/xr_map_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XR address map and XR bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package xr_map_pkg;

localparam int XR_DATA_W   = 16;        // XR data word
localparam int XR_REG_W    = 5;         // register number width
localparam int XR_INDEX_W  = 12;        // memory region index width
localparam int INTR_W      = 4;         // interrupt sources
localparam int COLOR_AW    = 8;         // 256 colour entries

// memory region codes, addr bits [13:12]
localparam logic [1:0] XR_REGION_COLOR  = 2'd0;
localparam logic [1:0] XR_REGION_TILE   = 2'd1;
localparam logic [1:0] XR_REGION_COPPER = 2'd2;
localparam logic [1:0] XR_REGION_SPRITE = 2'd3;

// register numbers
localparam logic [XR_REG_W-1:0] XR_REG_INTR_MASK   = 5'd0;
localparam logic [XR_REG_W-1:0] XR_REG_INTR_STATUS = 5'd1;

// register form, top bit clear
typedef struct packed {
    logic                           is_mem;     // 0 here
    logic [XR_DATA_W-XR_REG_W-2:0]  spare;
    logic [XR_REG_W-1:0]            num;        // register number
} xr_reg_addr_t;

// memory form, top bit set
typedef struct packed {
    logic                   is_mem;             // 1 here
    logic                   spare;
    logic [1:0]             region;             // XR_REGION_*
    logic [XR_INDEX_W-1:0]  index;              // word within region
} xr_mem_addr_t;

// same 16-bit XR address seen both ways
typedef union packed {
    xr_reg_addr_t regs;
    xr_mem_addr_t mem;
} xr_addr_u;

typedef struct packed {
    logic                   strobe;             // single cycle
    xr_addr_u               addr;
    logic [XR_DATA_W-1:0]   data;
} xr_wr_t;

typedef struct packed {
    logic                   strobe;             // single cycle
    xr_addr_u               addr;
} xr_rd_t;

typedef struct packed {
    logic                   strobe;
    logic [XR_REG_W-1:0]    num;
    logic [XR_DATA_W-1:0]   data;
} reg_wr_t;

typedef struct packed {
    logic                   strobe;
    logic [COLOR_AW-1:0]    index;
    logic [XR_DATA_W-1:0]   data;               // XRGB word
} color_wr_t;

endpackage

`default_nettype wire

// File: verilog/video_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel and colour types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package video_pkg;

localparam int CHAN_W      = 4;         // bits per colour channel
localparam int PIX_INDEX_W = 8;         // colour index in pixel stream

// colour RAM word, x nibble unused by output
typedef struct packed {
    logic [CHAN_W-1:0]  x;
    logic [CHAN_W-1:0]  red;
    logic [CHAN_W-1:0]  green;
    logic [CHAN_W-1:0]  blue;
} xrgb_t;

typedef struct packed {
    logic [CHAN_W-1:0]  red;
    logic [CHAN_W-1:0]  green;
    logic [CHAN_W-1:0]  blue;
} rgb_t;

typedef struct packed {
    logic               hsync;
    logic               vsync;
    logic               de;             // display enable
} sync_t;

typedef struct packed {
    logic [PIX_INDEX_W-1:0] index;      // colour index
    sync_t                  sync;       // hsync, vsync, de
} pixel_t;

endpackage

`default_nettype wire

// File: verilog/xr_write_arb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XR write arbiter, CPU over copper
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module xr_write_arb
    import xr_map_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire xr_wr_t     cpu_wr_i,       // CPU register port write
    input  wire xr_wr_t     copper_wr_i,    // copper write
    output reg_wr_t         reg_wr_o,       // to xr_regs
    output color_wr_t       color_wr_o      // to colour RAM
);

localparam int HIT_REG   = 0;
localparam int HIT_COLOR = 1;

reg_wr_t    reg_next;
color_wr_t  color_next;
logic [1:0] cpu_hit;        // per target hit, CPU
logic [1:0] cop_hit;        // per target hit, copper

// which target a write lands on, none for dropped regions
function automatic logic [1:0] target_hit(input xr_wr_t wr);
    logic [1:0] hit;
    hit = 2'b00;
    if (wr.strobe) begin
        if (!wr.addr.regs.is_mem) begin
            hit[HIT_REG] = 1'b1;
        end else begin
            case (wr.addr.mem.region)
                XR_REGION_COLOR:  hit[HIT_COLOR] = 1'b1;
                XR_REGION_TILE,
                XR_REGION_COPPER,
                XR_REGION_SPRITE: hit = 2'b00;   // not implemented, dropped
                default:          hit = 2'b00;
            endcase
        end
    end
    return hit;
endfunction

always_comb begin
    cpu_hit = target_hit(cpu_wr_i);
    cop_hit = target_hit(copper_wr_i);

    // register target, CPU first
    reg_next.strobe = cpu_hit[HIT_REG] | cop_hit[HIT_REG];
    if (cpu_hit[HIT_REG]) begin
        reg_next.num  = cpu_wr_i.addr.regs.num;
        reg_next.data = cpu_wr_i.data;
    end else begin
        reg_next.num  = copper_wr_i.addr.regs.num;
        reg_next.data = copper_wr_i.data;
    end

    // colour target, copper only wins if CPU is elsewhere
    color_next.strobe = cpu_hit[HIT_COLOR] | cop_hit[HIT_COLOR];
    if (cpu_hit[HIT_COLOR]) begin
        color_next.index = cpu_wr_i.addr.mem.index[COLOR_AW-1:0];
        color_next.data  = cpu_wr_i.data;
    end else begin
        color_next.index = copper_wr_i.addr.mem.index[COLOR_AW-1:0];
        color_next.data  = copper_wr_i.data;
    end
end

// one register stage, only strobes cleared by reset
always_ff @(posedge clk) begin
    reg_wr_o   <= reg_next;
    color_wr_o <= color_next;
    if (reset_i) begin
        reg_wr_o.strobe   <= 1'b0;
        color_wr_o.strobe <= 1'b0;
    end
end

// no target write out of thin air
a_reg_src: assert property (@(posedge clk) disable iff (reset_i)
    reg_wr_o.strobe |-> $past(cpu_wr_i.strobe || copper_wr_i.strobe));
a_color_src: assert property (@(posedge clk) disable iff (reset_i)
    color_wr_o.strobe |-> $past(cpu_wr_i.strobe || copper_wr_i.strobe));

endmodule

`default_nettype wire

// File: verilog/xr_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XR registers, interrupt mask and status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module xr_regs
    import xr_map_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire reg_wr_t                reg_wr_i,       // from arbiter
    input  wire xr_rd_t                 cpu_rd_i,       // CPU read strobe
    input  wire logic [INTR_W-1:0]      intr_signal_i,  // interrupt sources
    output logic [XR_DATA_W-1:0]        rd_data_o,
    output logic                        rd_valid_o,
    output logic                        bus_intr_o      // CPU interrupt strobe
);

logic [INTR_W-1:0]      intr_mask;      // enabled sources
logic [INTR_W-1:0]      intr_status;    // pending sources
logic [INTR_W-1:0]      intr_clear;     // write-one-to-clear bits
logic                   mask_wr;
logic [XR_DATA_W-1:0]   rd_word;        // readback mux

assign mask_wr = reg_wr_i.strobe && (reg_wr_i.num == XR_REG_INTR_MASK);

// ack bits only on a status write
always_comb begin
    intr_clear = '0;
    if (reg_wr_i.strobe && (reg_wr_i.num == XR_REG_INTR_STATUS)) begin
        intr_clear = reg_wr_i.data[INTR_W-1:0];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_mask   <= '0;
        intr_status <= '0;
        bus_intr_o  <= 1'b0;
    end else begin
        if (mask_wr) begin
            intr_mask <= reg_wr_i.data[INTR_W-1:0];
        end
        // strobe only on a new, enabled source
        bus_intr_o  <= |(intr_signal_i & intr_mask & ~intr_status);
        // latch new signals, drop acked ones
        intr_status <= (intr_status | intr_signal_i) & ~intr_clear;
    end
end

// readback decode, memory form reads as zero
always_comb begin
    rd_word = '0;
    if (!cpu_rd_i.addr.regs.is_mem) begin
        case (cpu_rd_i.addr.regs.num)
            XR_REG_INTR_MASK:   rd_word[INTR_W-1:0] = intr_mask;
            XR_REG_INTR_STATUS: rd_word[INTR_W-1:0] = intr_status;
            default:            rd_word = '0;   // unused register
        endcase
    end
end

always_ff @(posedge clk) begin
    rd_data_o <= rd_word;                       // qualified by rd_valid_o
    if (reset_i) begin
        rd_valid_o <= 1'b0;
    end else begin
        rd_valid_o <= cpu_rd_i.strobe;
    end
end

// read answer exactly one cycle later, never otherwise
a_rd_follows: assert property (@(posedge clk) disable iff (reset_i)
    cpu_rd_i.strobe |=> rd_valid_o);
a_rd_caused: assert property (@(posedge clk) disable iff (reset_i)
    rd_valid_o |-> $past(cpu_rd_i.strobe));

endmodule

`default_nettype wire

// File: verilog/color_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Colour lookup RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module color_mem
    import xr_map_pkg::*;
    import video_pkg::*;
(
    input  wire logic                   clk,
    input  wire color_wr_t              color_wr_i,     // write port
    input  wire logic [COLOR_AW-1:0]    rd_index_i,     // lookup index
    output xrgb_t                       rd_xrgb_o       // one cycle later
);

localparam int DEPTH = 2**COLOR_AW;

xrgb_t mem [0:DEPTH-1];     // 256 x 16 block RAM

// write port
always_ff @(posedge clk) begin
    if (color_wr_i.strobe) begin
        mem[color_wr_i.index] <= xrgb_t'(color_wr_i.data);
    end
end

// read port, always enabled, old data on same-address write
always_ff @(posedge clk) begin
    rd_xrgb_o <= mem[rd_index_i];
end

endmodule

`default_nettype wire

// File: verilog/video_out.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Colour lookup output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module video_out
    import xr_map_pkg::*;
    import video_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire pixel_t                 pixel_i,        // index and sync in
    output logic [COLOR_AW-1:0]         color_index_o,  // to colour RAM
    input  wire xrgb_t                  xrgb_i,         // RAM word, 1 cycle
    output rgb_t                        rgb_o,          // blanked colour
    output sync_t                       sync_o          // 2 cycle delayed sync
);

sync_t sync_q;      // sync aligned with RAM output

assign color_index_o = pixel_i.index;   // RAM registers the read

always_ff @(posedge clk) begin
    if (reset_i) begin
        sync_q <= '0;
        sync_o <= '0;
        rgb_o  <= '0;
    end else begin
        sync_q <= pixel_i.sync;         // stage 1, RAM read
        sync_o <= sync_q;               // stage 2, output reg
        if (sync_q.de) begin
            rgb_o <= '{red: xrgb_i.red, green: xrgb_i.green, blue: xrgb_i.blue};
        end else begin
            rgb_o <= '0;                // blanking
        end
    end
end

// no colour outside the visible area
a_blank: assert property (@(posedge clk) disable iff (reset_i)
    !sync_o.de |-> (rgb_o == '0));

endmodule

`default_nettype wire

// File: verilog/xr_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XR register and colour output top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module xr_top
    import xr_map_pkg::*;
    import video_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xr_wr_t                 cpu_wr_i,       // CPU XR write
    input  wire xr_wr_t                 copper_wr_i,    // copper XR write
    input  wire xr_rd_t                 cpu_rd_i,       // CPU XR read
    input  wire pixel_t                 pixel_i,        // pixel stream
    input  wire logic [INTR_W-1:0]      intr_signal_i,  // interrupt sources
    output logic [XR_DATA_W-1:0]        rd_data_o,
    output logic                        rd_valid_o,
    output rgb_t                        rgb_o,
    output sync_t                       sync_o,
    output logic                        bus_intr_o
);

reg_wr_t                reg_wr;         // arbiter to registers
color_wr_t              color_wr;       // arbiter to colour RAM
logic [COLOR_AW-1:0]    color_index;    // lookup index
xrgb_t                  color_xrgb;     // lookup result

// input side
xr_write_arb xr_write_arb (
    .clk            (clk),
    .reset_i        (reset_i),
    .cpu_wr_i       (cpu_wr_i),
    .copper_wr_i    (copper_wr_i),
    .reg_wr_o       (reg_wr),
    .color_wr_o     (color_wr)
);

// registers and interrupts
xr_regs xr_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_i       (reg_wr),
    .cpu_rd_i       (cpu_rd_i),
    .intr_signal_i  (intr_signal_i),
    .rd_data_o      (rd_data_o),
    .rd_valid_o     (rd_valid_o),
    .bus_intr_o     (bus_intr_o)
);

// palette
color_mem color_mem (
    .clk            (clk),
    .color_wr_i     (color_wr),
    .rd_index_i     (color_index),
    .rd_xrgb_o      (color_xrgb)
);

// output side
video_out video_out (
    .clk            (clk),
    .reset_i        (reset_i),
    .pixel_i        (pixel_i),
    .color_index_o  (color_index),
    .xrgb_i         (color_xrgb),
    .rgb_o          (rgb_o),
    .sync_o         (sync_o)
);

endmodule

`default_nettype wire

// File: testbench/tb_xr_vectors.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XR top test vectors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// inputs driven at one clock step, idle where unused
typedef struct packed {
    logic               used;
    logic [2:0]         test;           // index into test_name
    xr_wr_t             cpu_wr;
    xr_wr_t             cop_wr;         // copper port
    xr_rd_t             rd;
    pixel_t             pixel;
    logic [INTR_W-1:0]  intr;
} stim_t;

// outputs seen at a step, rgb comes from the model entry
typedef struct packed {
    logic               rd_valid;
    logic [15:0]        rd_data;        // only with rd_valid
    logic [7:0]         rgb_index;      // don't care while de low
    sync_t              sync;
    logic               intr;
} expect_t;

localparam int N_STEPS = 31;
localparam logic [2:0] T_LUT   = 3'd0;
localparam logic [2:0] T_SAME  = 3'd1;
localparam logic [2:0] T_SPLIT = 3'd2;
localparam logic [2:0] T_INTR  = 3'd3;
localparam logic [2:0] T_BLANK = 3'd4;
localparam xr_wr_t NO_WR = '0;
localparam xr_rd_t NO_RD = '0;
localparam pixel_t NO_PX = '0;

string test_name [0:4] = '{"colour lookup", "same index write", "split targets",
                           "interrupts", "blanking"};

stim_t   stim_tab [0:N_STEPS-1];
expect_t exp_tab  [0:N_STEPS-1];

// memory form, data drawn when driven
function automatic xr_wr_t mem_write(input logic [1:0] region, input logic [7:0] index);
    return {1'b1, 1'b1, 1'b0, region, 4'h0, index, 16'h0000};
endfunction

function automatic xr_wr_t reg_write(input logic [4:0] num, input logic [15:0] data);
    return {1'b1, 1'b0, 10'h000, num, data};    // register form
endfunction

function automatic xr_rd_t reg_read(input logic [4:0] num);
    return {1'b1, 1'b0, 10'h000, num};
endfunction

task automatic load_vectors();
    for (int i = 0; i < N_STEPS; i++) begin
        stim_tab[i] = '0;
        exp_tab[i]  = '0;
    end
    // write at k, pixel at k+2, rgb at k+4
    stim_tab[0]  = '{1'b1, T_LUT, mem_write(XR_REGION_COLOR, 8'h21), NO_WR, NO_RD, NO_PX, 4'h0};
    stim_tab[2]  = '{1'b1, T_LUT, NO_WR, NO_WR, NO_RD, {8'h21, 3'b101}, 4'h0};
    stim_tab[5]  = '{1'b1, T_SAME, mem_write(XR_REGION_COLOR, 8'h40),
                     mem_write(XR_REGION_COLOR, 8'h40), NO_RD, NO_PX, 4'h0};
    stim_tab[7]  = '{1'b1, T_SAME, NO_WR, NO_WR, NO_RD, {8'h40, 3'b011}, 4'h0};
    stim_tab[10] = '{1'b1, T_SPLIT, reg_write(XR_REG_INTR_MASK, 16'h0005),
                     mem_write(XR_REGION_COLOR, 8'h7f), NO_RD, NO_PX, 4'h0};
    stim_tab[11] = '{1'b1, T_SPLIT, NO_WR, mem_write(XR_REGION_TILE, 8'h21), NO_RD, NO_PX, 4'h0};
    stim_tab[12] = '{1'b1, T_SPLIT, NO_WR, NO_WR, reg_read(XR_REG_INTR_MASK),
                     {8'h7f, 3'b001}, 4'h0};
    stim_tab[13] = '{1'b1, T_SPLIT, NO_WR, NO_WR, NO_RD, {8'h21, 3'b001}, 4'h0};
    stim_tab[16] = '{1'b1, T_INTR, NO_WR, NO_WR, NO_RD, NO_PX, 4'b0001};
    stim_tab[17] = '{1'b1, T_INTR, NO_WR, NO_WR, reg_read(XR_REG_INTR_STATUS), NO_PX, 4'h0};
    stim_tab[18] = '{1'b1, T_INTR, NO_WR, NO_WR, NO_RD, NO_PX, 4'b0001};   // still pending
    stim_tab[20] = '{1'b1, T_INTR, reg_write(XR_REG_INTR_STATUS, 16'h0001), NO_WR, NO_RD,
                     NO_PX, 4'h0};
    stim_tab[22] = '{1'b1, T_INTR, NO_WR, NO_WR, reg_read(XR_REG_INTR_STATUS), NO_PX, 4'b0010};
    stim_tab[24] = '{1'b1, T_INTR, NO_WR, NO_WR, reg_read(XR_REG_INTR_STATUS), NO_PX, 4'h0};
    stim_tab[26] = '{1'b1, T_BLANK, NO_WR, NO_WR, {1'b1, 16'h8000}, {8'h21, 3'b110}, 4'h0};
    stim_tab[27] = '{1'b1, T_BLANK, NO_WR, NO_WR, NO_RD, {8'h40, 3'b010}, 4'h0};
    exp_tab[4]   = '{1'b0, 16'h0000, 8'h21, 3'b101, 1'b0};
    exp_tab[9]   = '{1'b0, 16'h0000, 8'h40, 3'b011, 1'b0};
    exp_tab[13]  = '{1'b1, 16'h0005, 8'h00, 3'b000, 1'b0};
    exp_tab[14]  = '{1'b0, 16'h0000, 8'h7f, 3'b001, 1'b0};
    exp_tab[15]  = '{1'b0, 16'h0000, 8'h21, 3'b001, 1'b0};   // tile write left it alone
    exp_tab[17]  = '{1'b0, 16'h0000, 8'h00, 3'b000, 1'b1};
    exp_tab[18]  = '{1'b1, 16'h0001, 8'h00, 3'b000, 1'b0};
    exp_tab[23]  = '{1'b1, 16'h0000, 8'h00, 3'b000, 1'b0};   // cleared, bit 1 not yet in
    exp_tab[25]  = '{1'b1, 16'h0002, 8'h00, 3'b000, 1'b0};
    exp_tab[27]  = '{1'b1, 16'h0000, 8'h00, 3'b000, 1'b0};
    exp_tab[28]  = '{1'b0, 16'h0000, 8'h00, 3'b110, 1'b0};
    exp_tab[29]  = '{1'b0, 16'h0000, 8'h00, 3'b010, 1'b0};
endtask

// File: testbench/tb_xr_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XR top testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module tb_xr_top
    import xr_map_pkg::*;
    import video_pkg::*;
();

logic                   clk;
logic                   reset_i;
xr_wr_t                 cpu_wr;
xr_wr_t                 copper_wr;
xr_rd_t                 cpu_rd;
pixel_t                 pixel;
logic [INTR_W-1:0]      intr_signal;
logic [XR_DATA_W-1:0]   rd_data;
logic                   rd_valid;
rgb_t                   rgb;
sync_t                  sync;
logic                   bus_intr;

integer     seed;                   // $random state
xrgb_t      color_model [0:255];    // colour RAM as written
int         step;
logic [2:0] test;                   // current test id

`include "tb_xr_vectors.svh"

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;          // 100 MHz
end

xr_top UUT (
    .clk            (clk),
    .reset_i        (reset_i),
    .cpu_wr_i       (cpu_wr),
    .copper_wr_i    (copper_wr),
    .cpu_rd_i       (cpu_rd),
    .pixel_i        (pixel),
    .intr_signal_i  (intr_signal),
    .rd_data_o      (rd_data),
    .rd_valid_o     (rd_valid),
    .rgb_o          (rgb),
    .sync_o         (sync),
    .bus_intr_o     (bus_intr)
);

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("Mismatch in %s at step %0d, %s: expected %h, actual %h",
                 test_name[test], step, what, expected, actual);
        $display(">>> FAIL");
        $fatal(1, "output mismatch");
    end
endtask

task automatic check_outputs(input expect_t e);
    xrgb_t  entry;
    rgb_t   want_rgb;
    entry    = color_model[e.rgb_index];
    want_rgb = '0;                              // blanked unless de
    if (e.sync.de) begin
        want_rgb = {entry.red, entry.green, entry.blue};
    end
    check_value("rd_valid", 32'(e.rd_valid), 32'(rd_valid));
    if (e.rd_valid) begin
        check_value("rd_data", 32'(e.rd_data), 32'(rd_data));
    end
    check_value("rgb", 32'(want_rgb), 32'(rgb));
    check_value("sync", 32'(e.sync), 32'(sync));
    check_value("bus_intr", 32'(e.intr), 32'(bus_intr));
endtask

task automatic drive_step(input stim_t s);
    xr_wr_t cpu;
    xr_wr_t cop;
    cpu = s.cpu_wr;
    cop = s.cop_wr;
    // memory form writes carry random XRGB words
    if (cpu.addr.mem.is_mem) begin
        cpu.data = 16'($random(seed));
    end
    if (cop.addr.mem.is_mem) begin
        cop.data = 16'($random(seed));
    end
    // copper first so a CPU write to the same entry wins
    if (cop.strobe && cop.addr.mem.is_mem && cop.addr.mem.region == XR_REGION_COLOR) begin
        color_model[cop.addr.mem.index[7:0]] = xrgb_t'(cop.data);
    end
    if (cpu.strobe && cpu.addr.mem.is_mem && cpu.addr.mem.region == XR_REGION_COLOR) begin
        color_model[cpu.addr.mem.index[7:0]] = xrgb_t'(cpu.data);
    end
    cpu_wr      = cpu;
    copper_wr   = cop;
    cpu_rd      = s.rd;
    pixel       = s.pixel;
    intr_signal = s.intr;
endtask

initial begin
    seed        = 32'hdc5feacb;
    reset_i     = 1'b1;
    cpu_wr      = '0;
    copper_wr   = '0;
    cpu_rd      = '0;
    pixel       = '0;
    intr_signal = '0;
    test        = '0;
    step        = 0;
    load_vectors();
    repeat (10) @(posedge clk);
    #1 reset_i = 1'b0;
    // check what the last edge produced, then drive the next step
    for (step = 0; step < N_STEPS; step++) begin
        @(posedge clk);
        #1;
        if (stim_tab[step].used) begin
            test = stim_tab[step].test;
        end
        check_outputs(exp_tab[step]);
        drive_step(stim_tab[step]);
    end
    $display(">>> PASS");
    $finish;
end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+testbench
verilog/xr_map_pkg.sv
verilog/video_pkg.sv
verilog/xr_write_arb.sv
verilog/xr_regs.sv
verilog/color_mem.sv
verilog/video_out.sv
verilog/xr_top.sv
testbench/tb_xr_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_xr_top
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
